// ==== Bender.yml ====
package:
  name: dot16_engine

sources:
  - src/dot_pkg.sv
  - src/delay_line.sv
  - src/mult_pipe.sv
  - src/dot8_unit.sv
  - src/dot16_unit.sv
  - src/dot_job_ctrl.sv
  - src/dot16_engine.sv
  - target: test
    files:
      - dv/dot16_engine_properties.sv
      - dv/dot16_engine_tb.sv

// ==== dv/dot16_engine_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot16_engine_properties #(
   parameter int MULT_LATENCY = 4,
   parameter int TREE_DELAY   = 1
) (
   input wire                      clk,
   input wire                      rst_n,
   input wire                      req,
   input wire                      ack,
   input wire dot_pkg::dot16_sum_t result
);

   localparam int LAT = MULT_LATENCY + 2 * TREE_DELAY;

   // Set from the accepting edge until the edge that drops ack
   logic        busy_q;
   logic        accept;

   // Number of failed assertions, watched by the testbench
   int unsigned fail_count = 0;

   // The engine accepts at the first edge that samples req while it is idle
   assign accept = req && !busy_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
      end else if (accept) begin
         busy_q <= 1'b1;
      end else if (ack && !req) begin
         busy_q <= 1'b0;
      end
   end

   // ----------------------------------------
   // Handshake and timing
   // ----------------------------------------

   // ack may only rise in answer to a req that was high at the previous edge
   ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(req))
      else begin
         $error("ack rose without a pending req");
         fail_count++;
      end

   // The result is frozen for the whole time ack is high
   result_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && $past(ack)) |-> $stable(result))
      else begin
         $error("result changed while ack was high");
         fail_count++;
      end

   // ack stays low for LAT plus 1 edges after the accepting edge, then rises
   ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> (!ack) [* LAT + 1] ##1 ack)
      else begin
         $error("ack did not rise LAT plus 1 cycles after the accepting edge");
         fail_count++;
      end

endmodule

`default_nettype wire

// ==== dv/dot16_engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot16_engine_tb;

   localparam int clk_period_ns = 40;
   // Jobs issued by all tests together, including the aborted one
   localparam int total_jobs    = 59;
   localparam int timeout_ns    = (total_jobs * 200 + 100) * clk_period_ns;
   // Longest wait for one handshake step, in cycles
   localparam int max_wait      = 200;

   logic                clk;
   logic                rst_n;
   logic                req;
   dot_pkg::dot_job_t   job;
   logic                ack;
   dot_pkg::dot16_sum_t result;
   int                  seed;

   dot16_engine dot16_engine_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .job    (job),
      .ack    (ack),
      .result (result)
   );

   bind dot16_engine dot16_engine_properties #(
      .MULT_LATENCY (MULT_LATENCY),
      .TREE_DELAY   (TREE_DELAY)
   ) engine_props_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .ack    (ack),
      .result (result)
   );

   always #(clk_period_ns / 2) clk = ~clk;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   // Inputs change 2 ns after each rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // Sum of sixteen signed lane products, computed in plain integers
   function automatic dot_pkg::dot16_sum_t ref_dot(input dot_pkg::dot_job_t j);
      int acc;
      acc = 0;
      for (int i = 0; i < dot_pkg::num_lanes; i++) begin
         acc += int'(j.a_vec[i]) * int'(j.b_vec[i]);
      end
      return dot_pkg::dot16_sum_t'(acc);
   endfunction

   function automatic dot_pkg::dot_job_t random_job();
      dot_pkg::dot_job_t j;
      for (int i = 0; i < 8; i++) begin
         j[32*i +: 32] = $random(seed);
      end
      return j;
   endfunction

   function automatic dot_pkg::dot_job_t uniform_job(input dot_pkg::operand_t a,
                                                     input dot_pkg::operand_t b);
      dot_pkg::dot_job_t j;
      for (int i = 0; i < dot_pkg::num_lanes; i++) begin
         j.a_vec[i] = a;
         j.b_vec[i] = b;
      end
      return j;
   endfunction

   // One full four-phase transaction; req is held for hold extra cycles after ack
   // and job may be scrambled while ack is high
   task automatic run_job(input dot_pkg::dot_job_t j, input int hold,
                          input bit scramble, output dot_pkg::dot16_sum_t got);
      dot_pkg::dot16_sum_t held;
      int                  waited;
      job    = j;
      req    = 1'b1;
      waited = 0;
      next_cycle();
      while (!ack) begin
         if (waited == max_wait) fail_run("ack never rose after req was raised");
         next_cycle();
         waited++;
      end
      held = result;
      if (scramble) job = random_job();
      repeat (hold) begin
         next_cycle();
         assert (ack) else fail_run("ack dropped while req was still high");
         assert (result === held)
            else fail_run($sformatf("Error: result expected %h actual %h", held, result));
      end
      req = 1'b0;
      next_cycle();
      // ack must be low again before the next job can be raised
      assert (!ack) else fail_run("ack stayed high after req fell");
      assert (result === held)
         else fail_run($sformatf("Error: result expected %h actual %h", held, result));
      got = held;
   endtask

   task automatic check_job(input string name, input dot_pkg::dot_job_t j,
                            input dot_pkg::dot16_sum_t expected, input int hold,
                            input bit scramble);
      dot_pkg::dot16_sum_t got;
      run_job(j, hold, scramble, got);
      assert (got === expected)
         else fail_run($sformatf("Error: result (%s) expected %h actual %h",
                                 name, expected, got));
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------

   task automatic test_simple_vectors();
      dot_pkg::dot_job_t j;
      int                lanes [4] = '{0, 7, 8, 15};
      check_job("all zero", '0, 20'sd0, 0, 1'b0);
      check_job("all ones", uniform_job(8'sd1, 8'sd1), 20'sd16, 0, 1'b0);
      // A single lane pair shows which half and which lane reaches the sum
      foreach (lanes[k]) begin
         j = '0;
         j.a_vec[lanes[k]] = dot_pkg::operand_t'(5 + lanes[k]);
         j.b_vec[lanes[k]] = -8'sd3;
         check_job("one hot", j, ref_dot(j), 0, 1'b0);
      end
   endtask

   task automatic test_signed_extremes();
      dot_pkg::dot_job_t j;
      check_job("min times min", uniform_job(-8'sd128, -8'sd128), 20'sd262144, 0, 1'b0);
      check_job("min times max", uniform_job(-8'sd128, 8'sd127), -20'sd260096, 0, 1'b0);
      j = uniform_job(8'sd100, 8'sd100);
      for (int i = 1; i < dot_pkg::num_lanes; i += 2) begin
         j.b_vec[i] = -8'sd100;
      end
      check_job("alternating signs", j, 20'sd0, 0, 1'b0);
   endtask

   task automatic test_random_jobs();
      dot_pkg::dot_job_t j;
      repeat (40) begin
         j = random_job();
         check_job("random", j, ref_dot(j), 0, 1'b0);
      end
   endtask

   // Back-pressure of 0 to 10 cycles, with job changed under every other ack
   task automatic test_handshake();
      dot_pkg::dot_job_t j;
      int                hold;
      for (int n = 0; n < 8; n++) begin
         j    = random_job();
         hold = {$random(seed)} % 11;
         check_job("held req", j, ref_dot(j), hold, n[0]);
      end
   endtask

   task automatic test_reset_mid_job();
      dot_pkg::dot_job_t j;
      job = random_job();
      req = 1'b1;
      // The first edge accepts, the next two are inside the run phase
      repeat (3) next_cycle();
      rst_n = 1'b0;
      req   = 1'b0;
      repeat (2) next_cycle();
      assert (!ack) else fail_run("ack was high after reset");
      assert (result === '0)
         else fail_run($sformatf("Error: result expected %h actual %h", 20'h0, result));
      rst_n = 1'b1;
      next_cycle();
      j = random_job();
      check_job("after reset", j, ref_dot(j), 0, 1'b0);
   endtask

   // ----------------------------------------
   // Sequence and watchdog
   // ----------------------------------------

   initial begin
      #(timeout_ns);
      fail_run($sformatf("Timeout after %0d ns, the handshake stopped making progress",
                         timeout_ns));
   end

   // A failed bound assertion ends the run in the same time step
   always @(dot16_engine_i.engine_props_i.fail_count) begin
      if (dot16_engine_i.engine_props_i.fail_count != 0) begin
         fail_run("A bound handshake or timing assertion failed");
      end
   end

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      req   = 1'b0;
      job   = '0;
      seed  = 62;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      next_cycle();
      test_simple_vectors();
      test_signed_extremes();
      test_random_jobs();
      test_handshake();
      test_reset_mid_job();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
src/dot_pkg.sv
src/delay_line.sv
src/mult_pipe.sv
src/dot8_unit.sv
src/dot16_unit.sv
src/dot_job_ctrl.sv
src/dot16_engine.sv
dv/dot16_engine_properties.sv
dv/dot16_engine_tb.sv

// ==== src/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
   parameter int  DEPTH     = 1,
   parameter type payload_t = logic
) (
   input  wire      clk,
   input  wire      rst_n,
   input  wire      ena,
   input  wire      payload_t din,
   output payload_t dout
);

   // One register per stage with stage 0 nearest the input
   payload_t stage_q [DEPTH];

   // ----------------------------------------
   // Shift chain
   // ----------------------------------------

   // The whole chain advances together and holds its contents while ena is low
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
         end
      end else if (ena) begin
         stage_q[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // The last stage is the retimed payload
   assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/dot16_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot16_engine #(
   parameter int MULT_LATENCY = 4,
   parameter int TREE_DELAY   = 1
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    req,
   input  wire dot_pkg::dot_job_t job,
   output logic                   ack,
   output dot_pkg::dot16_sum_t    result
);

   // Enabled cycles from operands to sum, one tree delay per add stage
   localparam int LAT = MULT_LATENCY + 2 * TREE_DELAY;

   // Registered job and pipeline enable from the controller
   dot_pkg::dot_job_t   job_q;
   logic                ena;

   // Dot product at the end of the pipeline
   dot_pkg::dot16_sum_t sum;

   // ----------------------------------------
   // Job controller
   // ----------------------------------------

   dot_job_ctrl #(
      .LATENCY (LAT)
   ) dot_job_ctrl_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .job    (job),
      .ack    (ack),
      .result (result),
      .job_q  (job_q),
      .ena    (ena),
      .sum    (sum)
   );

   // ----------------------------------------
   // Datapath
   // ----------------------------------------

   dot16_unit #(
      .MULT_LATENCY (MULT_LATENCY),
      .TREE_DELAY   (TREE_DELAY)
   ) dot16_unit_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .job   (job_q),
      .sum   (sum)
   );

endmodule

`default_nettype wire

// ==== src/dot16_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot16_unit #(
   parameter int MULT_LATENCY = 4,
   parameter int TREE_DELAY   = 1
) (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    ena,
   input  wire dot_pkg::dot_job_t job,
   output dot_pkg::dot16_sum_t    sum
);

   // Partial sums from the low half (lanes 0 to 7) and the high half (8 to 15)
   dot_pkg::dot8_sum_t  half_sum [2];

   // Partial sums widened to the result width and their total
   dot_pkg::dot16_sum_t half_ext [2];
   dot_pkg::dot16_sum_t total;

   // ----------------------------------------
   // Two half dot products
   // ----------------------------------------

   for (genvar h = 0; h < 2; h++) begin : g_half
      dot8_unit #(
         .MULT_LATENCY (MULT_LATENCY),
         .TREE_DELAY   (TREE_DELAY)
      ) dot8_unit_i (
         .clk    (clk),
         .rst_n  (rst_n),
         .ena    (ena),
         .a_half (job.a_vec[8*h+7 : 8*h]),
         .b_half (job.b_vec[8*h+7 : 8*h]),
         .sum    (half_sum[h])
      );

      // The cast keeps the sign since the partial sum is a signed type
      assign half_ext[h] = dot_pkg::dot16_sum_t'(half_sum[h]);
   end

   // ----------------------------------------
   // Final add
   // ----------------------------------------

   assign total = half_ext[0] + half_ext[1];

   // Another TREE_DELAY stages for the last adder
   delay_line #(
      .DEPTH     (TREE_DELAY),
      .payload_t (dot_pkg::dot16_sum_t)
   ) final_dl_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .din   (total),
      .dout  (sum)
   );

endmodule

`default_nettype wire

// ==== src/dot8_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot8_unit #(
   parameter int MULT_LATENCY = 4,
   parameter int TREE_DELAY   = 1
) (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      ena,
   input  wire dot_pkg::operand_t [7:0] a_half,
   input  wire dot_pkg::operand_t [7:0] b_half,
   output dot_pkg::dot8_sum_t       sum
);

   // Each tree level gains one bit over the level below it
   localparam int L1_W = $bits(dot_pkg::product_t) + 1;
   localparam int L2_W = L1_W + 1;

   typedef logic signed [L1_W-1:0] level1_t;
   typedef logic signed [L2_W-1:0] level2_t;

   // Multiplier outputs for the eight lanes of this half
   dot_pkg::product_t  products [8];

   // Intermediate sums of the adder tree
   level1_t            level1 [4];
   level2_t            level2 [2];
   dot_pkg::dot8_sum_t tree_sum;

   // ----------------------------------------
   // Multipliers
   // ----------------------------------------

   // All lanes share ena so their products arrive in the same cycle
   for (genvar lane = 0; lane < 8; lane++) begin : g_mult
      mult_pipe #(
         .MULT_LATENCY (MULT_LATENCY)
      ) mult_pipe_i (
         .clk     (clk),
         .rst_n   (rst_n),
         .ena     (ena),
         .a       (a_half[lane]),
         .b       (b_half[lane]),
         .product (products[lane])
      );
   end

   // ----------------------------------------
   // Adder tree
   // ----------------------------------------

   // Operands are sign extended to the level width before each add
   // so no level can overflow
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         level1[i] = level1_t'(products[2*i]) + level1_t'(products[2*i+1]);
      end
      for (int i = 0; i < 2; i++) begin
         level2[i] = level2_t'(level1[2*i]) + level2_t'(level1[2*i+1]);
      end
      tree_sum = dot_pkg::dot8_sum_t'(level2[0]) + dot_pkg::dot8_sum_t'(level2[1]);
   end

   // The tree is purely combinational, so the delay line supplies its
   // TREE_DELAY cycles of retiming
   delay_line #(
      .DEPTH     (TREE_DELAY),
      .payload_t (dot_pkg::dot8_sum_t)
   ) tree_dl_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .din   (tree_sum),
      .dout  (sum)
   );

endmodule

`default_nettype wire

// ==== src/dot_job_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_job_ctrl #(
   parameter int LATENCY = 6
) (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     req,
   input  wire dot_pkg::dot_job_t  job,
   output logic                    ack,
   output dot_pkg::dot16_sum_t     result,
   output dot_pkg::dot_job_t       job_q,
   output logic                    ena,
   input  wire dot_pkg::dot16_sum_t sum
);

   // Wide enough to hold LATENCY-1 for any legal latency
   localparam int CNT_W = $clog2(LATENCY + 1);

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_done,
      st_release
   } state_t;

   state_t           state_q;
   logic [CNT_W-1:0] count_q;
   logic             accept;
   logic             last_run;

   // ----------------------------------------
   // Decode
   // ----------------------------------------

   // A new job is taken only from idle, so a second req cannot overlap a job
   assign accept = (state_q == st_idle) && req;

   // Set in the final run cycle
   assign last_run = (count_q == CNT_W'(LATENCY - 1));

   // The pipeline moves only during run, which lasts exactly LATENCY cycles
   assign ena = (state_q == st_run);

   // ----------------------------------------
   // Job register
   // ----------------------------------------

   // The job is held here for the whole run so the requester may change its
   // inputs as soon as ack rises
   always_ff @(posedge clk) begin
      if (accept) begin
         job_q <= job;
      end
   end

   // ----------------------------------------
   // Handshake FSM
   // ----------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
         count_q <= '0;
         ack     <= 1'b0;
         result  <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               // The accepting edge also clears the cycle count
               if (accept) begin
                  state_q <= st_run;
                  count_q <= '0;
               end
            end
            st_run: begin
               count_q <= count_q + 1'b1;
               if (last_run) begin
                  state_q <= st_done;
               end
            end
            st_done: begin
               // The pipeline is frozen here so sum is stable while it is captured
               result  <= sum;
               ack     <= 1'b1;
               state_q <= st_release;
            end
            st_release: begin
               // Result and ack hold for as long as the requester keeps req high
               if (!req) begin
                  ack     <= 1'b0;
                  state_q <= st_idle;
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/dot_pkg.sv ====
`default_nettype none

package dot_pkg;

   // ----------------------------------------
   // Job geometry
   // ----------------------------------------

   // Element pairs carried by one job
   localparam int num_lanes = 16;

   // Operand width is fixed here because every operand type below depends on it
   localparam int operand_w = 8;

   // ----------------------------------------
   // Datapath types
   // ----------------------------------------

   // One signed operand as it enters a multiplier
   typedef logic signed [operand_w-1:0] operand_t;

   // A full vector of operands with lane 0 in the low bits
   typedef operand_t [num_lanes-1:0] operand_vec_t;

   // Full precision product of two operands
   typedef logic signed [2*operand_w-1:0] product_t;

   // Sum of eight products needs three extra bits of growth
   typedef logic signed [2*operand_w+2:0] dot8_sum_t;

   // Sum of sixteen products is the job result
   typedef logic signed [2*operand_w+3:0] dot16_sum_t;

   // One complete job as presented by the requester
   typedef struct packed {
      operand_vec_t a_vec;
      operand_vec_t b_vec;
   } dot_job_t;

endpackage

`default_nettype wire

// ==== src/mult_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_pipe #(
   parameter int MULT_LATENCY = 4
) (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                ena,
   input  wire dot_pkg::operand_t a,
   input  wire dot_pkg::operand_t b,
   output dot_pkg::product_t  product
);

   // Raw product before the pipeline registers
   dot_pkg::product_t product_raw;

   // ----------------------------------------
   // Multiply
   // ----------------------------------------

   // Both operands are signed so the product is formed in two's complement
   // and already has its full 16-bit width
   assign product_raw = a * b;

   // ----------------------------------------
   // Pipeline
   // ----------------------------------------

   // The delay line stands in for the internal registers of a hard multiplier
   // and gives MULT_LATENCY enabled cycles from operands to product
   delay_line #(
      .DEPTH     (MULT_LATENCY),
      .payload_t (dot_pkg::product_t)
   ) product_dl_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .din   (product_raw),
      .dout  (product)
   );

endmodule

`default_nettype wire
